// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cpu_axi_bridge
FILELIST = cpu_axi.f

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: run check clean

$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^SIMULATION PASSED$$'

check: run

clean:
	rm -rf obj_dir

// ==== bench/cpu_axi_bridge_props.sv ====
// --------------------------------------------------
// bridge assertions, axi valid stability,
// one-cycle client pulses and idle outputs in reset
// --------------------------------------------------
`timescale 1ns/100ps

module cpu_axi_bridge_props (
    input logic               aclk,
    input logic               arst_n,
    input cpu_axi_pkg::addr_t araddr,
    input logic               arvalid,
    input logic               arready,
    input logic               rready,
    input cpu_axi_pkg::addr_t awaddr,
    input logic               awvalid,
    input logic               awready,
    input cpu_axi_pkg::data_t wdata,
    input cpu_axi_pkg::strb_t wstrb,
    input logic               wvalid,
    input logic               wready,
    input logic               bready,
    input logic               ibus_addr_ok,
    input logic               ibus_data_ok,
    input logic               dbus_addr_ok,
    input logic               dbus_data_ok,
    input logic               ubus_addr_ok,
    input logic               ubus_data_ok
);
    // valid and payload hold until ready
    ar_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr)) else $error("ar not held");
    aw_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr)) else $error("aw not held");
    w_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("w not held");

    // client pulses last one cycle
    ia_pulse: assert property (@(posedge aclk) disable iff (!arst_n)
        ibus_addr_ok |=> !ibus_addr_ok) else $error("ibus_addr_ok too long");
    id_pulse: assert property (@(posedge aclk) disable iff (!arst_n)
        ibus_data_ok |=> !ibus_data_ok) else $error("ibus_data_ok too long");
    da_pulse: assert property (@(posedge aclk) disable iff (!arst_n)
        dbus_addr_ok |=> !dbus_addr_ok) else $error("dbus_addr_ok too long");
    dd_pulse: assert property (@(posedge aclk) disable iff (!arst_n)
        dbus_data_ok |=> !dbus_data_ok) else $error("dbus_data_ok too long");
    ua_pulse: assert property (@(posedge aclk) disable iff (!arst_n)
        ubus_addr_ok |=> !ubus_addr_ok) else $error("ubus_addr_ok too long");
    ud_pulse: assert property (@(posedge aclk) disable iff (!arst_n)
        ubus_data_ok |=> !ubus_data_ok) else $error("ubus_data_ok too long");

    reset_idle: assert property (@(posedge aclk) !arst_n |->
        !arvalid && !rready && !awvalid && !wvalid && !bready &&
        !ibus_addr_ok && !ibus_data_ok && !dbus_addr_ok && !dbus_data_ok &&
        !ubus_addr_ok && !ubus_data_ok) else $error("control output high in reset");
endmodule

bind cpu_axi_bridge cpu_axi_bridge_props u_props (
    .aclk(aclk), .arst_n(arst_n), .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rready(rready), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready), .bready(bready),
    .ibus_addr_ok(ibus_addr_ok), .ibus_data_ok(ibus_data_ok),
    .dbus_addr_ok(dbus_addr_ok), .dbus_data_ok(dbus_data_ok),
    .ubus_addr_ok(ubus_addr_ok), .ubus_data_ok(ubus_data_ok)
);

// ==== bench/cpu_axi_stimulus.txt ====
// op addr wdata wstrb exp_data exp_err (op 0 ibus, 1 dbus, 2 store, 3 both reads, f end)
// op 3: addr is the dbus address, wdata the ibus address, wstrb the ibus expected word
0 00001000 00000000 0        5a5a4a5a 0
2 00002000 11223344 3        00000000 0
1 00002000 00000000 0        5a5a3344 0
3 00003000 00004000 5a5a1a5a 5a5a6a5a 0
0 80000010 00000000 0        00000000 1
2 80000020 deadbeef f        00000000 1
1 80000020 00000000 0        00000000 1
2 00001000 cafef00d f        00000000 0
1 00001000 00000000 0        cafef00d 0
0 00001004 00000000 0        5a5a4a5e 0
2 00005002 0000ab00 2        00000000 0
1 00005000 00000000 0        5a5aab5a 0
3 00005000 00001000 cafef00d 5a5aab5a 0
f 00000000 00000000 0        00000000 0

// ==== bench/tb_cpu_axi_bridge.sv ====
// --------------------------------------------------
// testbench for the cpu axi bridge
// axi4-lite slave memory model and client drivers
// --------------------------------------------------
`timescale 1ns/100ps

module tb_cpu_axi_bridge;
    import cpu_axi_pkg::*;

    localparam int MAX_OPS = 16;
    localparam int TIMEOUT = 100;   // cycles per wait

    logic  aclk, arst_n;
    logic  ibus_req, dbus_req, ubus_req;
    addr_t ibus_addr, dbus_addr, ubus_addr;
    logic  ibus_addr_ok, ibus_data_ok, ibus_err;
    logic  dbus_addr_ok, dbus_data_ok, dbus_err;
    data_t ibus_rdata, dbus_rdata, ubus_wdata;
    strb_t ubus_wstrb;
    logic  ubus_addr_ok, ubus_data_ok, ubus_err;
    addr_t araddr, awaddr;
    logic  arvalid, arready, rvalid, rready, awvalid, awready;
    logic  wvalid, wready, bvalid, bready;
    data_t rdata, wdata;
    resp_t rresp, bresp;
    strb_t wstrb;

    logic [31:0] stim [0:MAX_OPS*6-1];
    data_t       mem [addr_t];   // word addressed slave memory
    int          seed, errors, timeouts, i;
    bit          store_busy;
    addr_t       store_addr;     // address of the store in flight
    time         t_i, t_d;

    cpu_axi_bridge u_cpu_axi_bridge (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    task check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task check_err(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task report_timeout(input string what);
        timeouts++;
        $display("timeout at %0t: gave up waiting for %s", $time, what);
    endtask

    task check_idle;
        check_err("arvalid", 1'b0, arvalid);
        check_err("rready", 1'b0, rready);
        check_err("awvalid", 1'b0, awvalid);
        check_err("wvalid", 1'b0, wvalid);
        check_err("bready", 1'b0, bready);
        check_err("ibus_addr_ok", 1'b0, ibus_addr_ok);
        check_err("ibus_data_ok", 1'b0, ibus_data_ok);
        check_err("dbus_addr_ok", 1'b0, dbus_addr_ok);
        check_err("dbus_data_ok", 1'b0, dbus_data_ok);
        check_err("ubus_addr_ok", 1'b0, ubus_addr_ok);
        check_err("ubus_data_ok", 1'b0, ubus_data_ok);
    endtask

    // unwritten words read back a pattern of their own address
    function automatic data_t mem_read(input addr_t a);
        addr_t w;
        w = {a[31:2], 2'b00};
        return mem.exists(w) ? mem[w] : (w ^ 32'h5a5a5a5a);
    endfunction

    // read slave serves one transaction at a time
    initial begin
        int d, n;
        addr_t a;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = '0;
        forever begin
            @(negedge aclk);
            if (arvalid) begin
                d = $random(seed) & 3;
                repeat (d) @(negedge aclk);
                arready = 1'b1;   // taken at the next rising edge
                a = araddr;
                @(negedge aclk);
                arready = 1'b0;
                d = $random(seed) & 3;
                repeat (d) @(negedge aclk);
                rvalid = 1'b1;
                rresp  = a[31] ? 2'b10 : RESP_OKAY;
                rdata  = a[31] ? '0 : mem_read(a);
                n = 0;
                while (!rready && n < TIMEOUT) begin
                    @(negedge aclk);
                    n++;
                end
                if (!rready) report_timeout("rready");
                @(negedge aclk);
                rvalid = 1'b0;
            end
        end
    end

    // write slave accepts aw and w after separate delays
    initial begin
        int d_aw, d_w, cnt, n;
        bit aw_seen, w_seen;
        addr_t wa;
        data_t wd, nd;
        strb_t ws;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = '0;
        forever begin
            @(negedge aclk);
            if (awvalid || wvalid) begin
                d_aw    = $random(seed) & 3;
                d_w     = $random(seed) & 3;
                aw_seen = 1'b0;
                w_seen  = 1'b0;
                cnt     = 0;
                while (!(aw_seen && w_seen) && cnt < TIMEOUT) begin
                    awready = !aw_seen && awvalid && cnt >= d_aw;
                    wready  = !w_seen && wvalid && cnt >= d_w;
                    if (awready) begin
                        aw_seen = 1'b1;
                        wa      = awaddr;
                    end
                    if (wready) begin
                        w_seen = 1'b1;
                        wd     = wdata;
                        ws     = wstrb;
                    end
                    cnt++;
                    @(negedge aclk);
                end
                awready = 1'b0;
                wready  = 1'b0;
                if (!(aw_seen && w_seen)) report_timeout("awvalid and wvalid");
                if (!wa[31]) begin
                    nd = mem_read(wa);
                    for (int b = 0; b < 4; b++) begin
                        if (ws[b]) nd[8*b +: 8] = wd[8*b +: 8];
                    end
                    mem[{wa[31:2], 2'b00}] = nd;
                end
                d_aw = $random(seed) & 3;
                repeat (d_aw) @(negedge aclk);
                bvalid = 1'b1;
                bresp  = wa[31] ? 2'b10 : RESP_OKAY;
                n = 0;
                while (!bready && n < TIMEOUT) begin
                    @(negedge aclk);
                    n++;
                end
                if (!bready) report_timeout("bready");
                @(negedge aclk);
                bvalid = 1'b0;
            end
        end
    end

    task automatic read_ibus(input addr_t a, input data_t exp, input logic exp_e,
                             output time t_ok);
        int  n;
        bit  seen;
        n = 0;
        seen = 0;
        t_ok = 0;
        @(negedge aclk);
        ibus_req  = 1'b1;
        ibus_addr = a;
        while (!seen && n < TIMEOUT) begin
            @(posedge aclk);
            seen = ibus_addr_ok;
            n++;
        end
        t_ok = $time;
        @(negedge aclk);
        ibus_req = 1'b0;
        if (!seen) begin
            report_timeout("ibus_addr_ok");
            return;
        end
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!ibus_data_ok && n < TIMEOUT);
        if (!ibus_data_ok) begin
            report_timeout("ibus_data_ok");
            return;
        end
        check_data("ibus_rdata", exp, ibus_rdata);
        check_err("ibus_err", exp_e, ibus_err);
    endtask

    task automatic read_dbus(input addr_t a, input data_t exp, input logic exp_e,
                             output time t_ok);
        int  n;
        bit  seen;
        n = 0;
        seen = 0;
        t_ok = 0;
        @(negedge aclk);
        dbus_req  = 1'b1;
        dbus_addr = a;
        while (!seen && n < TIMEOUT) begin
            @(posedge aclk);
            seen = dbus_addr_ok;
            n++;
        end
        t_ok = $time;
        // a load of the same word must wait for the store's data_ok
        if (seen && store_busy && (a[31:2] == store_addr[31:2])) begin
            errors++;
            $display("dbus read of %h accepted while a store to that word was pending at %0t",
                     a, $time);
        end
        @(negedge aclk);
        dbus_req = 1'b0;
        if (!seen) begin
            report_timeout("dbus_addr_ok");
            return;
        end
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!dbus_data_ok && n < TIMEOUT);
        if (!dbus_data_ok) begin
            report_timeout("dbus_data_ok");
            return;
        end
        check_data("dbus_rdata", exp, dbus_rdata);
        check_err("dbus_err", exp_e, dbus_err);
    endtask

    task automatic watch_store(input logic exp_e);
        int n;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!ubus_data_ok && n < TIMEOUT);
        if (!ubus_data_ok) report_timeout("ubus_data_ok");
        else check_err("ubus_err", exp_e, ubus_err);
        store_busy = 1'b0;
    endtask

    task automatic wait_store_idle;
        int n;
        n = 0;
        while (store_busy && n < TIMEOUT) begin
            @(negedge aclk);
            n++;
        end
        if (store_busy) report_timeout("previous store to finish");
    endtask

    // returns after addr_ok so a following load can overlap the store
    task automatic write_ubus(input addr_t a, input data_t wd, input strb_t ws,
                              input logic exp_e);
        int n;
        bit seen;
        n = 0;
        seen = 0;
        @(negedge aclk);
        ubus_req   = 1'b1;
        ubus_addr  = a;
        ubus_wdata = wd;
        ubus_wstrb = ws;
        while (!seen && n < TIMEOUT) begin
            @(posedge aclk);
            seen = ubus_addr_ok;
            n++;
        end
        @(negedge aclk);
        ubus_req = 1'b0;
        if (!seen) begin
            report_timeout("ubus_addr_ok");
            return;
        end
        store_addr = a;
        store_busy = 1'b1;
        fork
            watch_store(exp_e);
        join_none
    endtask

    initial begin
        logic [31:0] op;
        bit          done;
        seed       = 32'h14134bd4;
        errors     = 0;
        timeouts   = 0;
        store_busy = 1'b0;
        store_addr = '0;
        done       = 1'b0;
        arst_n     = 1'b0;
        ibus_req   = 1'b0;
        dbus_req   = 1'b0;
        ubus_req   = 1'b0;
        ibus_addr  = '0;
        dbus_addr  = '0;
        ubus_addr  = '0;
        ubus_wdata = '0;
        ubus_wstrb = '0;
        $readmemh("bench/cpu_axi_stimulus.txt", stim);

        repeat (2) begin
            @(negedge aclk);
            check_idle();
        end
        arst_n = 1'b1;
        repeat (2) begin
            @(negedge aclk);
            check_idle();   // nothing moves before the first request
        end

        for (i = 0; i < MAX_OPS && !done; i++) begin
            op = stim[i*6];
            case (op)
                0: read_ibus(stim[i*6+1], stim[i*6+4], stim[i*6+5][0], t_i);
                1: read_dbus(stim[i*6+1], stim[i*6+4], stim[i*6+5][0], t_d);
                2: begin
                    wait_store_idle();
                    write_ubus(stim[i*6+1], stim[i*6+2], stim[i*6+3][3:0],
                               stim[i*6+5][0]);
                end
                3: begin
                    fork
                        read_dbus(stim[i*6+1], stim[i*6+4], stim[i*6+5][0], t_d);
                        read_ibus(stim[i*6+2], stim[i*6+3], 1'b0, t_i);
                    join
                    if (t_d > t_i) begin
                        errors++;
                        $display("dbus was accepted after ibus at %0t", $time);
                    end
                end
                32'hf: done = 1'b1;
                default: begin
                    errors++;
                    $display("unknown op %h in stimulus line %0d", op, i);
                end
            endcase
        end
        wait_store_idle();
        repeat (2) @(negedge aclk);

        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end
endmodule

// ==== cpu_axi.f ====
src/cpu_axi_pkg.sv
src/cpu_rd_if.sv
src/cpu_wr_if.sv
src/axi_read_arbiter.sv
src/axi_write_channel.sv
src/cpu_axi_bridge.sv
bench/cpu_axi_bridge_props.sv
bench/tb_cpu_axi_bridge.sv

// ==== src/axi_read_arbiter.sv ====
// --------------------------------------------------
// read arbiter, ibus and dbus onto axi ar/r
// dbus wins, loads that hit a pending store wait
// --------------------------------------------------
`timescale 1ns/100ps

module axi_read_arbiter (
    input  logic               aclk,
    input  logic               arst_n,
    cpu_rd_if.arbiter          ibus,
    cpu_rd_if.arbiter          dbus,
    output cpu_axi_pkg::addr_t araddr,
    output logic               arvalid,
    input  logic               arready,
    input  cpu_axi_pkg::data_t rdata,
    input  cpu_axi_pkg::resp_t rresp,
    input  logic               rvalid,
    output logic               rready,
    input  logic               wr_pending,
    input  cpu_axi_pkg::addr_t wr_pending_addr
);
    import cpu_axi_pkg::*;

    localparam int ADDR_MSB = $bits(addr_t) - 1;

    rd_state_e state;
    rd_state_e state_nxt;
    addr_t     addr_q;        // address of the granted read
    logic      sel_dbus_q;    // 1 when dbus owns the current read
    data_t     rdata_q;
    logic      err_q;
    logic      data_ok_q;

    logic      dbus_hit;
    logic      grant_d;
    logic      grant_i;
    logic      r_fire;

    // same word as the store still on its way out
    assign dbus_hit = wr_pending &&
                      (dbus.addr[ADDR_MSB:WORD_LSB] == wr_pending_addr[ADDR_MSB:WORD_LSB]);

    assign grant_d = (state == RD_IDLE) && dbus.req && !dbus_hit;
    assign grant_i = (state == RD_IDLE) && ibus.req && !grant_d;
    assign r_fire  = rvalid && rready;

    always_comb begin
        state_nxt = state;
        case (state)
            RD_IDLE: if (grant_d || grant_i) state_nxt = RD_ADDR;
            RD_ADDR: if (arready)            state_nxt = RD_DATA;
            RD_DATA: if (rvalid)             state_nxt = RD_IDLE;
            default:                         state_nxt = RD_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= RD_IDLE;
            sel_dbus_q <= 1'b0;
            data_ok_q  <= 1'b0;
        end else begin
            state     <= state_nxt;
            data_ok_q <= r_fire;   // data_ok one cycle after the r handshake
            if (grant_d || grant_i) begin
                sel_dbus_q <= grant_d;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (grant_d || grant_i) begin
            addr_q <= grant_d ? dbus.addr : ibus.addr;
        end
        if (r_fire) begin
            rdata_q <= rdata;
            err_q   <= (rresp != RESP_OKAY);
        end
    end

    // axi side
    assign araddr  = addr_q;
    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);

    // client side, completion goes only to the winner
    assign ibus.addr_ok = grant_i;
    assign dbus.addr_ok = grant_d;
    assign ibus.data_ok = data_ok_q && !sel_dbus_q;
    assign dbus.data_ok = data_ok_q && sel_dbus_q;
    assign ibus.rdata   = rdata_q;
    assign dbus.rdata   = rdata_q;
    assign ibus.err     = ibus.data_ok && err_q;
    assign dbus.err     = dbus.data_ok && err_q;

endmodule

// ==== src/axi_write_channel.sv ====
// --------------------------------------------------
// store engine, ubus onto axi aw/w/b
// also flags the store that is still in flight
// --------------------------------------------------
`timescale 1ns/100ps

module axi_write_channel (
    input  logic               aclk,
    input  logic               arst_n,
    cpu_wr_if.channel          ubus,
    output cpu_axi_pkg::addr_t awaddr,
    output logic               awvalid,
    input  logic               awready,
    output cpu_axi_pkg::data_t wdata,
    output cpu_axi_pkg::strb_t wstrb,
    output logic               wvalid,
    input  logic               wready,
    input  cpu_axi_pkg::resp_t bresp,
    input  logic               bvalid,
    output logic               bready,
    output logic               wr_pending,
    output cpu_axi_pkg::addr_t wr_pending_addr
);
    import cpu_axi_pkg::*;

    wr_state_e state;
    addr_t     addr_q;
    data_t     wdata_q;
    strb_t     wstrb_q;
    logic      aw_done;      // aw handshake seen
    logic      w_done;       // w handshake seen
    logic      err_q;
    logic      data_ok_q;

    logic      accept;
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;

    assign accept  = (state == WR_IDLE) && ubus.req;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= WR_IDLE;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= b_fire;
            case (state)
                WR_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (accept) state <= WR_SEND;
                end
                WR_SEND: begin
                    if (aw_fire) aw_done <= 1'b1;
                    if (w_fire)  w_done  <= 1'b1;
                    // either order of ready is fine
                    if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: if (b_fire) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q  <= ubus.addr;
            wdata_q <= ubus.wdata;
            wstrb_q <= ubus.wstrb;
        end
        if (b_fire) err_q <= (bresp != RESP_OKAY);
    end

    assign awaddr  = addr_q;
    assign awvalid = (state == WR_SEND) && !aw_done;
    assign wdata   = wdata_q;
    assign wstrb   = wstrb_q;
    assign wvalid  = (state == WR_SEND) && !w_done;
    assign bready  = (state == WR_RESP);

    assign ubus.addr_ok = accept;
    assign ubus.data_ok = data_ok_q;
    assign ubus.err     = data_ok_q && err_q;

    // covers the acceptance cycle so a same-cycle load is held too
    assign wr_pending      = accept || (state != WR_IDLE);
    assign wr_pending_addr = accept ? ubus.addr : addr_q;

endmodule

// ==== src/cpu_axi_bridge.sv ====
// --------------------------------------------------
// cpu to axi4-lite bridge, top level
// two read clients and one store client on one port
// --------------------------------------------------
`timescale 1ns/100ps

module cpu_axi_bridge (
    input  logic               aclk,
    input  logic               arst_n,
    // instruction reads
    input  logic               ibus_req,
    input  cpu_axi_pkg::addr_t ibus_addr,
    output logic               ibus_addr_ok,
    output logic               ibus_data_ok,
    output cpu_axi_pkg::data_t ibus_rdata,
    output logic               ibus_err,
    // data reads
    input  logic               dbus_req,
    input  cpu_axi_pkg::addr_t dbus_addr,
    output logic               dbus_addr_ok,
    output logic               dbus_data_ok,
    output cpu_axi_pkg::data_t dbus_rdata,
    output logic               dbus_err,
    // uncached stores
    input  logic               ubus_req,
    input  cpu_axi_pkg::addr_t ubus_addr,
    input  cpu_axi_pkg::data_t ubus_wdata,
    input  cpu_axi_pkg::strb_t ubus_wstrb,
    output logic               ubus_addr_ok,
    output logic               ubus_data_ok,
    output logic               ubus_err,
    // axi4-lite master
    output cpu_axi_pkg::addr_t araddr,
    output logic               arvalid,
    input  logic               arready,
    input  cpu_axi_pkg::data_t rdata,
    input  cpu_axi_pkg::resp_t rresp,
    input  logic               rvalid,
    output logic               rready,
    output cpu_axi_pkg::addr_t awaddr,
    output logic               awvalid,
    input  logic               awready,
    output cpu_axi_pkg::data_t wdata,
    output cpu_axi_pkg::strb_t wstrb,
    output logic               wvalid,
    input  logic               wready,
    input  cpu_axi_pkg::resp_t bresp,
    input  logic               bvalid,
    output logic               bready
);
    cpu_rd_if ibus_if ();
    cpu_rd_if dbus_if ();
    cpu_wr_if ubus_if ();

    cpu_axi_pkg::addr_t wr_pending_addr;   // store-to-load link
    logic               wr_pending;

    assign ibus_if.req   = ibus_req;
    assign ibus_if.addr  = ibus_addr;
    assign ibus_addr_ok  = ibus_if.addr_ok;
    assign ibus_data_ok  = ibus_if.data_ok;
    assign ibus_rdata    = ibus_if.rdata;
    assign ibus_err      = ibus_if.err;

    assign dbus_if.req   = dbus_req;
    assign dbus_if.addr  = dbus_addr;
    assign dbus_addr_ok  = dbus_if.addr_ok;
    assign dbus_data_ok  = dbus_if.data_ok;
    assign dbus_rdata    = dbus_if.rdata;
    assign dbus_err      = dbus_if.err;

    assign ubus_if.req   = ubus_req;
    assign ubus_if.addr  = ubus_addr;
    assign ubus_if.wdata = ubus_wdata;
    assign ubus_if.wstrb = ubus_wstrb;
    assign ubus_addr_ok  = ubus_if.addr_ok;
    assign ubus_data_ok  = ubus_if.data_ok;
    assign ubus_err      = ubus_if.err;

    axi_read_arbiter u_read_arbiter (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .ibus            (ibus_if.arbiter),
        .dbus            (dbus_if.arbiter),
        .araddr          (araddr),
        .arvalid         (arvalid),
        .arready         (arready),
        .rdata           (rdata),
        .rresp           (rresp),
        .rvalid          (rvalid),
        .rready          (rready),
        .wr_pending      (wr_pending),
        .wr_pending_addr (wr_pending_addr)
    );

    axi_write_channel u_write_channel (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .ubus            (ubus_if.channel),
        .awaddr          (awaddr),
        .awvalid         (awvalid),
        .awready         (awready),
        .wdata           (wdata),
        .wstrb           (wstrb),
        .wvalid          (wvalid),
        .wready          (wready),
        .bresp           (bresp),
        .bvalid          (bvalid),
        .bready          (bready),
        .wr_pending      (wr_pending),
        .wr_pending_addr (wr_pending_addr)
    );

endmodule

// ==== src/cpu_axi_pkg.sv ====
// --------------------------------------------------
// cpu axi bridge package
// bus word types, axi response code and fsm states
// --------------------------------------------------

package cpu_axi_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] data_t;   // bus word
    typedef logic [3:0]  strb_t;   // byte write strobes
    typedef logic [1:0]  resp_t;   // axi response code

    localparam resp_t RESP_OKAY = 2'b00;

    // low address bits dropped when a load is matched against a pending store
    localparam int WORD_LSB = 2;

    typedef enum logic [1:0] {
        RD_IDLE,   // waiting for a client request
        RD_ADDR,   // ar channel valid
        RD_DATA    // waiting on r channel
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,   // waiting for a store
        WR_SEND,   // aw and w in flight
        WR_RESP    // waiting on b channel
    } wr_state_e;

endpackage

// ==== src/cpu_rd_if.sv ====
// --------------------------------------------------
// read-only client port
// request / addr_ok / data_ok handshake with data
// --------------------------------------------------
`timescale 1ns/100ps

interface cpu_rd_if;
    import cpu_axi_pkg::*;

    logic  req;
    addr_t addr;
    logic  addr_ok;   // one-cycle pulse, request taken
    logic  data_ok;   // one-cycle pulse, rdata and err valid
    data_t rdata;
    logic  err;

    modport client  (output req, addr, input  addr_ok, data_ok, rdata, err);
    modport arbiter (input  req, addr, output addr_ok, data_ok, rdata, err);

endinterface

// ==== src/cpu_wr_if.sv ====
// --------------------------------------------------
// write-only client port
// request / addr_ok / data_ok handshake for stores
// --------------------------------------------------
`timescale 1ns/100ps

interface cpu_wr_if;
    import cpu_axi_pkg::*;

    logic  req;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    logic  addr_ok;   // store accepted
    logic  data_ok;   // store completed on axi
    logic  err;       // valid with data_ok

    modport client (
        output req, addr, wdata, wstrb,
        input  addr_ok, data_ok, err
    );
    modport channel (
        input  req, addr, wdata, wstrb,
        output addr_ok, data_ok, err
    );

endinterface
